//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tcp_tx_tb \
		-Mdir obj_dir -f build.f
	./obj_dir/Vtcp_tx_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Something failed" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "test did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk #(
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic fsm_rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  // release lines up with the stimulus, 1 ns after the edge
  initial begin
    fsm_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 fsm_rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/tcp_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_tb
  import tcp_tx_pkg::*;
();

  localparam int RAM_DEPTH = 10;
  localparam int RAM_SIZE  = 1 << RAM_DEPTH;
  localparam int TIMEOUT   = 200;

  logic        clk;
  logic        fsm_rst;
  logic        hdr_v;
  logic [15:0] src_port, dst_port, win_size, urg_ptr;
  logic [31:0] seq_num, ack_num, src_ip, dst_ip;
  logic [8:0]  flags;
  logic [15:0] payload_len, payload_chsum;
  logic [15:0] mss;
  logic [7:0]  win_scale;
  logic [31:0] ts_snd, ts_rec;
  logic        mss_pres, win_pres, sack_perm_pres, ts_pres;
  logic [RAM_DEPTH-1:0] queue_addr;
  logic [7:0]  queue_data = 8'h00;
  logic [7:0]  d;
  logic        v, sof, eof, busy;

  logic [7:0]  ram [0:RAM_SIZE-1]; // payload queue
  logic [15:0] lfsr;
  logic [7:0]  exp_q [$];
  logic [7:0]  rx_q [$];
  int          sof_cnt, eof_cnt;
  bit          armed, seg_done, prev_eof;
  int          errors, errors_before, tests_run, tests_failed;

  tb_clk #(.RST_CYCLES(8)) tb_clk_i (.clk(clk), .fsm_rst(fsm_rst));

  tcp_tx_top #(.RAM_DEPTH(RAM_DEPTH)) tcp_tx_top_i (.*);

  // queue RAM with registered read
  always @(posedge clk) queue_data <= ram[queue_addr];

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // partial sum of the payload as the upper layer would hand it over
  function automatic logic [15:0] payload_sum();
    logic [31:0] sum;
    logic [15:0] word;
    logic [RAM_DEPTH-1:0] a;
    sum = 32'd0;
    for (int i = 0; i < payload_len; i += 2) begin
      a = seq_num[RAM_DEPTH-1:0] + RAM_DEPTH'(i);
      word[15:8] = ram[a];
      word[7:0]  = (i + 1 < payload_len) ? ram[a + 1'b1] : 8'h00; // odd tail padded
      sum += {16'h0, word};
    end
    while (sum[31:16] != 16'd0) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    return sum[15:0];
  endfunction

  function automatic void push_word(input logic [31:0] w);
    for (int k = 3; k >= 0; k--) exp_q.push_back(w[8*k +: 8]);
  endfunction

  function automatic void expected_segment();
    logic [31:0] opts [$];
    logic [31:0] sum;
    logic [15:0] tcp_len;
    logic [15:0] cs;
    logic [3:0]  offset;
    logic [RAM_DEPTH-1:0] a;
    exp_q.delete();
    // fixed option order, present ones back to back
    if (mss_pres) opts.push_back({TCP_OPT_MSS, 8'd4, mss});
    if (win_pres) opts.push_back({TCP_OPT_NOP, TCP_OPT_WIN, 8'd3, win_scale});
    if (sack_perm_pres) opts.push_back({TCP_OPT_NOP, TCP_OPT_NOP, TCP_OPT_SACK_PERM, 8'd2});
    if (ts_pres) begin
      opts.push_back({TCP_OPT_NOP, TCP_OPT_NOP, TCP_OPT_TS, 8'd10});
      opts.push_back(ts_snd);
      opts.push_back(ts_rec);
    end
    offset  = 4'(5 + opts.size());
    tcp_len = {10'd0, offset, 2'b00} + payload_len;
    push_word({src_port, dst_port});
    push_word(seq_num);
    push_word(ack_num);
    push_word({offset, 3'b000, flags, win_size});
    push_word({16'h0000, urg_ptr}); // checksum zero for now
    foreach (opts[k]) push_word(opts[k]);
    sum = {16'h0, src_ip[31:16]} + {16'h0, src_ip[15:0]};
    sum += {16'h0, dst_ip[31:16]} + {16'h0, dst_ip[15:0]};
    sum += {24'h0, PROTO_TCP} + {16'h0, tcp_len} + {16'h0, payload_chsum};
    for (int k = 0; k < exp_q.size() / 2; k++) sum += {16'h0, exp_q[2*k], exp_q[2*k+1]};
    while (sum[31:16] != 16'd0) sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    cs = ~sum[15:0];
    exp_q[16] = cs[15:8];
    exp_q[17] = cs[7:0];
    for (int i = 0; i < payload_len; i++) begin
      a = seq_num[RAM_DEPTH-1:0] + RAM_DEPTH'(i); // wraps around the queue
      exp_q.push_back(ram[a]);
    end
  endfunction

  function automatic void random_fields();
    src_port  = take_bits(16);
    dst_port  = take_bits(16);
    seq_num   = take_bits(32);
    ack_num   = take_bits(32);
    flags     = take_bits(9);
    win_size  = take_bits(16);
    urg_ptr   = take_bits(16);
    src_ip    = take_bits(32);
    dst_ip    = take_bits(32);
    mss       = take_bits(16);
    win_scale = take_bits(8);
    ts_snd    = take_bits(32);
    ts_rec    = take_bits(32);
    {mss_pres, win_pres, sack_perm_pres, ts_pres} = take_bits(4);
    payload_len = 16'(take_bits(6) % 61);
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_idle(input string when);
    if ({v, sof, eof, busy} !== 4'b0000) begin
      errors++;
      $display("[ERROR] {v,sof,eof,busy} %s: got %h, expected 0", when, {v, sof, eof, busy});
    end
  endtask

  task automatic pulse_hdr_v();
    hdr_v = 1'b1;
    tick();
    hdr_v = 1'b0;
  endtask

  task automatic start_segment();
    payload_chsum = payload_sum();
    expected_segment();
    rx_q.delete();
    sof_cnt  = 0;
    eof_cnt  = 0;
    seg_done = 1'b0;
    armed    = 1'b1;
    pulse_hdr_v();
    if (busy !== 1'b1) begin
      errors++;
      $display("[ERROR] busy after hdr_v: got %h, expected 1", busy);
    end
  endtask

  task automatic finish_segment();
    int n;
    n = 0;
    while (!seg_done && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (!seg_done) begin
      errors++;
      $display("timeout: segment did not end within %0d cycles", TIMEOUT);
      armed = 1'b0;
    end
    if (rx_q.size() != exp_q.size()) begin
      errors++;
      $display("[ERROR] byte count: got %h, expected %h", rx_q.size(), exp_q.size());
    end
    if (sof_cnt != 1 || eof_cnt != 1) begin
      errors++;
      $display("sof seen %0d times and eof %0d times, expected once each", sof_cnt, eof_cnt);
    end
    tick();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // compares the stream against the reference bytes, sampled mid cycle
  always @(negedge clk) begin
    if (prev_eof && busy !== 1'b0) begin
      errors++;
      $display("[ERROR] busy after eof: got %h, expected 0", busy);
    end
    prev_eof = (v === 1'b1) && (eof === 1'b1);
    if (v === 1'b1) begin
      if (!armed) begin
        errors++;
        $display("stream byte seen while no segment was expected");
      end else begin
        if (rx_q.size() >= exp_q.size()) begin
          errors++;
          $display("more bytes than the expected %0d", exp_q.size());
        end else if (d !== exp_q[rx_q.size()]) begin
          errors++;
          $display("[ERROR] d at byte %0d: got %h, expected %h", rx_q.size(), d,
                   exp_q[rx_q.size()]);
        end
        if (sof !== (rx_q.size() == 0)) begin
          errors++;
          $display("[ERROR] sof at byte %0d: got %h, expected %h", rx_q.size(), sof,
                   rx_q.size() == 0);
        end
        if (eof !== (rx_q.size() == exp_q.size() - 1)) begin
          errors++;
          $display("[ERROR] eof at byte %0d: got %h, expected %h", rx_q.size(), eof,
                   rx_q.size() == exp_q.size() - 1);
        end
        if (sof === 1'b1) sof_cnt++;
        if (eof === 1'b1) eof_cnt++;
        rx_q.push_back(d);
        if (eof === 1'b1) begin
          armed    = 1'b0;
          seg_done = 1'b1;
        end
      end
    end else begin
      if (armed && rx_q.size() > 0) begin
        errors++;
        $display("v dropped after %0d of %0d bytes", rx_q.size(), exp_q.size());
        armed = 1'b0;
      end
      if (sof === 1'b1 || eof === 1'b1) begin
        errors++;
        $display("[ERROR] sof/eof without v: got %h/%h, expected 0/0", sof, eof);
      end
    end
  end

  initial begin
    int n;
    lfsr = 16'd77;
    for (int a = 0; a < RAM_SIZE; a++) ram[a] = take_bits(8);
    hdr_v         = 1'b0;
    payload_chsum = 16'h0;
    random_fields();

    // reset state, no start pulse
    n = 0;
    while (fsm_rst !== 1'b0 && n < TIMEOUT) begin
      tick();
      check_idle("during reset");
      n++;
    end
    if (fsm_rst !== 1'b0) begin
      errors++;
      $display("timeout: reset was never released");
    end
    repeat (10) begin
      tick();
      check_idle("after reset");
    end
    end_test("reset state");

    random_fields();
    {mss_pres, win_pres, sack_perm_pres, ts_pres} = 4'b0000;
    payload_len = 16'd0;
    start_segment();
    finish_segment();
    if (rx_q.size() != 20) begin
      errors++;
      $display("[ERROR] segment length: got %h, expected %h", rx_q.size(), 20);
    end
    end_test("no options, no payload");

    random_fields();
    {mss_pres, win_pres, sack_perm_pres, ts_pres} = 4'b1111;
    payload_len = 16'd37;
    seq_num = (seq_num & ~32'h3FF) | 32'h3F0; // payload crosses the top of the queue
    start_segment();
    finish_segment();
    if (rx_q.size() > 12 && rx_q[12][7:4] != 4'd11) begin
      errors++;
      $display("[ERROR] offset: got %h, expected %h", rx_q[12][7:4], 4'd11);
    end
    end_test("all options, 37 payload bytes");

    for (int s = 0; s < 20; s++) begin
      random_fields();
      start_segment();
      finish_segment();
    end
    end_test("20 random segments");

    random_fields();
    {mss_pres, win_pres, sack_perm_pres, ts_pres} = 4'b1010;
    payload_len = 16'd12;
    start_segment();
    repeat (3) tick();
    pulse_hdr_v(); // lands in the option phase
    n = 0;
    while (sof !== 1'b1 && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (sof !== 1'b1) begin
      errors++;
      $display("timeout: no sof within %0d cycles", TIMEOUT);
    end
    pulse_hdr_v(); // and one while sending
    finish_segment();
    repeat (60) begin
      tick();
      if (busy !== 1'b0) begin
        errors++;
        $display("[ERROR] busy after the segment: got %h, expected 0", busy);
      end
    end
    end_test("start pulse while busy");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
common/tcp_tx_pkg.sv
src/tcp_tx_cnt.sv
src/tcp_tx_ctrl.sv
options/tcp_opt_asm.sv
checksum/tcp_chsum.sv
src/tcp_tx_ser.sv
src/tcp_tx_top.sv
bench/tb_clk.sv
bench/tcp_tx_tb.sv

//--- checksum/tcp_chsum.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_chsum import tcp_tx_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        sum_load,
  input  logic        sum_step,
  input  logic [31:0] src_ip,
  input  logic [31:0] dst_ip,
  input  logic [2:0]  opt_words,
  input  logic [15:0] payload_len,
  input  logic [15:0] payload_chsum,
  input  tcp_hdr_u    hdr_bytes,
  output logic [15:0] chsum
);

  // pseudo-header minus its first word, then the whole header register
  localparam int SH_BITS = 16 + 32 + 16 + 16 + $bits(tcp_hdr_u);

  logic [15:0]        tcp_len;
  logic [SH_BITS-1:0] words;
  logic [31:0]        acc;
  logic [16:0]        fold;

  assign tcp_len = 16'(MIN_HDR_BYTES) + {11'd0, opt_words, 2'b00} + payload_len;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      acc <= 32'd0;
    end else if (sum_load) begin
      acc <= {16'h0, payload_chsum} + {16'h0, src_ip[31:16]}; // load cycle adds word 0
    end else if (sum_step) begin
      acc <= acc + {16'h0, words[SH_BITS-1 -: 16]};
    end
  end

  always_ff @(posedge clk) begin
    if (sum_load) words <= {src_ip[15:0], dst_ip, 8'h00, PROTO_TCP, tcp_len, hdr_bytes.bytes};
    else if (sum_step) words <= {words[SH_BITS-17:0], 16'h0};
  end

  // acc stays far below 2^21, so two folds are enough
  assign fold  = {1'b0, acc[15:0]} + {1'b0, acc[31:16]};
  assign chsum = ~(fold[15:0] + {15'd0, fold[16]});

endmodule

`default_nettype wire

//--- common/tcp_tx_pkg.sv
`default_nettype none

package tcp_tx_pkg;

  // option kind bytes
  localparam logic [7:0] TCP_OPT_NOP       = 8'd1;
  localparam logic [7:0] TCP_OPT_MSS       = 8'd2;
  localparam logic [7:0] TCP_OPT_WIN       = 8'd3;
  localparam logic [7:0] TCP_OPT_SACK_PERM = 8'd4;
  localparam logic [7:0] TCP_OPT_TS        = 8'd8;

  localparam logic [7:0] PROTO_TCP = 8'd6; // pseudo-header protocol

  localparam int MIN_HDR_BYTES = 20;
  localparam int MAX_OPT_WORDS = 6;
  localparam int MAX_HDR_BYTES = MIN_HDR_BYTES + 4 * MAX_OPT_WORDS;

  typedef logic [31:0] opt_word_t;

  // fixed part, wire order
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    logic [3:0]  offset;
    logic [2:0]  reserved;
    logic [8:0]  flags;
    logic [15:0] win_size;
    logic [15:0] chsum;
    logic [15:0] urg_ptr;
  } tcp_fix_hdr_t;

  // written by fields, read and shifted as bytes
  typedef union packed {
    struct packed {
      tcp_fix_hdr_t                  fix;
      opt_word_t [0:MAX_OPT_WORDS-1] opt;
    } f;
    logic [0:MAX_HDR_BYTES-1][7:0] bytes; // byte 0 first on the wire
  } tcp_hdr_u;

endpackage

`default_nettype wire

//--- options/tcp_opt_asm.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_opt_asm import tcp_tx_pkg::*; (
  input  logic                          clk,
  input  logic                          fsm_rst,
  input  logic                          opt_load,
  input  logic                          opt_shift,
  input  logic [15:0]                   mss,
  input  logic                          mss_pres,
  input  logic [7:0]                    win_scale,
  input  logic                          win_pres,
  input  logic                          sack_perm_pres,
  input  logic [31:0]                   ts_snd,
  input  logic [31:0]                   ts_rec,
  input  logic                          ts_pres,
  output opt_word_t [0:MAX_OPT_WORDS-1] opt_bytes,
  output logic [2:0]                    opt_words
);

  opt_word_t [0:MAX_OPT_WORDS-1] proto; // all possible words, fixed order
  logic      [0:MAX_OPT_WORDS-1] pres;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      pres      <= '0;
      opt_words <= 3'd0;
    end else if (opt_load) begin
      pres      <= {mss_pres, win_pres, sack_perm_pres, {3{ts_pres}}}; // ts takes three words
      opt_words <= 3'd0;
    end else if (opt_shift) begin
      pres <= {pres[1:MAX_OPT_WORDS-1], 1'b0};
      if (pres[0]) opt_words <= opt_words + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (opt_load) begin
      proto <= {
        {TCP_OPT_MSS, 8'd4, mss},
        {TCP_OPT_NOP, TCP_OPT_WIN, 8'd3, win_scale},
        {TCP_OPT_NOP, TCP_OPT_NOP, TCP_OPT_SACK_PERM, 8'd2},
        {TCP_OPT_NOP, TCP_OPT_NOP, TCP_OPT_TS, 8'd10},
        ts_snd,
        ts_rec
      };
      opt_bytes <= '0;
    end else if (opt_shift) begin
      proto <= {proto[1:MAX_OPT_WORDS-1], 32'h0};
      // present words land back to back
      if (pres[0]) opt_bytes[opt_words] <= proto[0];
    end
  end

endmodule

`default_nettype wire

//--- src/tcp_tx_cnt.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_cnt (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       load,
  input  logic [7:0] value,
  input  logic       step,
  output logic       last
);

  logic [7:0] count;
  logic       armed;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      count <= 8'd0;
      armed <= 1'b0;
    end else if (load) begin
      count <= value - 8'd1; // last shows after value cycles
      armed <= 1'b1;
    end else if (step) begin
      if (count == 8'd0) armed <= 1'b0;
      else count <= count - 8'd1;
    end
  end

  assign last = armed && (count == 8'd0);

  // step comes from the controller busy level, so every busy cycle must be covered
  a_step_armed: assert property (@(posedge clk) disable iff (fsm_rst) step |-> armed)
    else $error("counter stepped while not armed");

endmodule

`default_nettype wire

//--- src/tcp_tx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_ctrl import tcp_tx_pkg::*; (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        hdr_v,
  input  logic [2:0]  opt_words,
  input  logic [15:0] payload_len,
  input  logic        cnt_last,
  output logic        cnt_load,
  output logic [7:0]  cnt_value,
  output logic        opt_load,
  output logic        opt_shift,
  output logic        build,
  output logic        sum_load,
  output logic        sum_step,
  output logic        seal,
  output logic        send,
  output logic        busy
);

  // one-hot state codes
  localparam logic [5:0] IDLE  = 6'b000001;
  localparam logic [5:0] OPT   = 6'b000010;
  localparam logic [5:0] BUILD = 6'b000100;
  localparam logic [5:0] SUM   = 6'b001000;
  localparam logic [5:0] SEAL  = 6'b010000;
  localparam logic [5:0] SEND  = 6'b100000;

  logic [5:0] state;
  logic [7:0] hdr_len;    // offset * 4
  logic [7:0] sum_cycles; // 6 pseudo words + 2 * offset
  logic [7:0] seg_len;    // segment limited to 255 bytes by the counter

  assign hdr_len    = 8'(MIN_HDR_BYTES) + {3'd0, opt_words, 2'b00};
  assign sum_cycles = 8'd6 + {1'b0, hdr_len[7:1]};
  assign seg_len    = hdr_len + payload_len[7:0];

  // length of the phase being entered
  always_comb begin
    cnt_load  = 1'b0;
    cnt_value = 8'd0;
    case (state)
      IDLE: begin
        cnt_load  = hdr_v;
        cnt_value = 8'(MAX_OPT_WORDS); // one cycle per prototype word
      end
      OPT: begin
        cnt_load  = cnt_last;
        cnt_value = 8'd1;
      end
      BUILD: begin
        cnt_load  = cnt_last;
        cnt_value = sum_cycles;
      end
      SUM: begin
        cnt_load  = cnt_last;
        cnt_value = 8'd1;
      end
      SEAL: begin
        cnt_load  = cnt_last;
        cnt_value = seg_len;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= IDLE;
      sum_load <= 1'b0;
    end else begin
      sum_load <= build; // header register is valid one cycle after build
      case (state)
        IDLE:    if (hdr_v) state <= OPT;
        OPT:     if (cnt_last) state <= BUILD;
        BUILD:   if (cnt_last) state <= SUM;
        SUM:     if (cnt_last) state <= SEAL;
        SEAL:    if (cnt_last) state <= SEND;
        SEND:    if (cnt_last) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  assign opt_load  = (state == IDLE) && hdr_v; // start pulses while busy are dropped
  assign opt_shift = (state == OPT);
  assign build     = (state == BUILD);
  assign sum_step  = (state == SUM);
  assign seal      = (state == SEAL);
  assign send      = (state == SEND);
  assign busy      = (state != IDLE);

  a_state_onehot: assert property (@(posedge clk) disable iff (fsm_rst) $onehot(state))
    else $error("controller state not one-hot");

  // seal lasts one cycle and the send run behind it is longer than one byte
  a_send_phase: assert property (@(posedge clk) disable iff (fsm_rst)
    seal |-> cnt_last ##1 (send && !cnt_last))
    else $error("send phase not entered from a single seal cycle");

endmodule

`default_nettype wire

//--- src/tcp_tx_ser.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_ser import tcp_tx_pkg::*; #(
  parameter int RAM_DEPTH = 10
) (
  input  logic                          clk,
  input  logic                          fsm_rst,
  input  logic                          build,
  input  logic                          seal,
  input  logic                          send,
  input  logic [15:0]                   src_port,
  input  logic [15:0]                   dst_port,
  input  logic [31:0]                   seq_num,
  input  logic [31:0]                   ack_num,
  input  logic [8:0]                    flags,
  input  logic [15:0]                   win_size,
  input  logic [15:0]                   urg_ptr,
  input  opt_word_t [0:MAX_OPT_WORDS-1] opt_bytes,
  input  logic [2:0]                    opt_words,
  input  logic [15:0]                   payload_len,
  input  logic [15:0]                   chsum,
  input  logic [7:0]                    queue_data,
  output tcp_hdr_u                      hdr_bytes,
  output logic [RAM_DEPTH-1:0]          queue_addr,
  output logic [7:0]                    d,
  output logic                          v,
  output logic                          sof,
  output logic                          eof
);

  logic [15:0] hdr_len;
  logic [15:0] seg_len;
  logic [15:0] byte_idx; // position of the byte on d

  assign hdr_len = 16'(MIN_HDR_BYTES) + {11'd0, opt_words, 2'b00};
  assign seg_len = hdr_len + payload_len;

  always_ff @(posedge clk) begin
    if (build) begin
      hdr_bytes.f.fix.src_port <= src_port;
      hdr_bytes.f.fix.dst_port <= dst_port;
      hdr_bytes.f.fix.seq_num  <= seq_num;
      hdr_bytes.f.fix.ack_num  <= ack_num;
      hdr_bytes.f.fix.offset   <= 4'd5 + {1'b0, opt_words};
      hdr_bytes.f.fix.reserved <= 3'd0;
      hdr_bytes.f.fix.flags    <= flags;
      hdr_bytes.f.fix.win_size <= win_size;
      hdr_bytes.f.fix.chsum    <= 16'h0; // zero while the sum runs
      hdr_bytes.f.fix.urg_ptr  <= urg_ptr;
      hdr_bytes.f.opt          <= opt_bytes;
    end else if (seal) begin
      hdr_bytes.bytes[16] <= chsum[15:8];
      hdr_bytes.bytes[17] <= chsum[7:0];
    end else if (send) begin
      hdr_bytes.bytes <= {hdr_bytes.bytes[1:MAX_HDR_BYTES-1], 8'h00};
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      byte_idx   <= 16'd0;
      queue_addr <= '0;
    end else if (build) begin
      byte_idx   <= 16'd0;
      queue_addr <= seq_num[RAM_DEPTH-1:0]; // payload starts at seq_num in the queue
    end else if (send) begin
      byte_idx <= byte_idx + 16'd1;
      // ram read takes a cycle, so the address runs one byte ahead
      if (byte_idx >= hdr_len - 16'd1) queue_addr <= queue_addr + RAM_DEPTH'(1);
    end
  end

  assign d   = (byte_idx < hdr_len) ? hdr_bytes.bytes[0] : queue_data;
  assign v   = send;
  assign sof = send && (byte_idx == 16'd0);
  assign eof = send && (byte_idx == seg_len - 16'd1);

  // the controller counter and the byte index must agree on the last byte
  a_eof_end: assert property (@(posedge clk) disable iff (fsm_rst) eof |-> v ##1 !v)
    else $error("eof without v or stream continues after eof");

endmodule

`default_nettype wire

//--- src/tcp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module tcp_tx_top import tcp_tx_pkg::*; #(
  parameter int RAM_DEPTH = 10
) (
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  logic                 hdr_v,
  input  logic [15:0]          src_port,
  input  logic [15:0]          dst_port,
  input  logic [31:0]          seq_num,
  input  logic [31:0]          ack_num,
  input  logic [8:0]           flags,
  input  logic [15:0]          win_size,
  input  logic [15:0]          urg_ptr,
  input  logic [31:0]          src_ip,
  input  logic [31:0]          dst_ip,
  input  logic [15:0]          payload_len,
  input  logic [15:0]          payload_chsum,
  input  logic [15:0]          mss,
  input  logic                 mss_pres,
  input  logic [7:0]           win_scale,
  input  logic                 win_pres,
  input  logic                 sack_perm_pres,
  input  logic [31:0]          ts_snd,
  input  logic [31:0]          ts_rec,
  input  logic                 ts_pres,
  output logic [RAM_DEPTH-1:0] queue_addr,
  input  logic [7:0]           queue_data,
  output logic [7:0]           d,
  output logic                 v,
  output logic                 sof,
  output logic                 eof,
  output logic                 busy
);

  logic opt_load, opt_shift, build, sum_load, sum_step, seal, send;
  logic cnt_load, cnt_last;
  logic [7:0] cnt_value;
  opt_word_t [0:MAX_OPT_WORDS-1] opt_bytes;
  logic [2:0] opt_words;
  tcp_hdr_u hdr_bytes;
  logic [15:0] chsum;

  // segment fields held for the whole segment
  logic [15:0] src_port_q, dst_port_q, win_size_q, urg_ptr_q;
  logic [31:0] seq_num_q, ack_num_q, src_ip_q, dst_ip_q;
  logic [8:0]  flags_q;
  logic [15:0] payload_len_q, payload_chsum_q;

  always_ff @(posedge clk) begin
    if (opt_load) begin // accepted start pulse
      src_port_q      <= src_port;
      dst_port_q      <= dst_port;
      seq_num_q       <= seq_num;
      ack_num_q       <= ack_num;
      flags_q         <= flags;
      win_size_q      <= win_size;
      urg_ptr_q       <= urg_ptr;
      src_ip_q        <= src_ip;
      dst_ip_q        <= dst_ip;
      payload_len_q   <= payload_len;
      payload_chsum_q <= payload_chsum;
    end
  end

  tcp_tx_ctrl tcp_tx_ctrl_i (
    .clk(clk), .fsm_rst(fsm_rst), .hdr_v(hdr_v), .opt_words(opt_words),
    .payload_len(payload_len_q), .cnt_last(cnt_last), .cnt_load(cnt_load),
    .cnt_value(cnt_value), .opt_load(opt_load), .opt_shift(opt_shift), .build(build),
    .sum_load(sum_load), .sum_step(sum_step), .seal(seal), .send(send), .busy(busy)
  );

  // phase counter ticks on every busy cycle
  tcp_tx_cnt tcp_tx_cnt_i (
    .clk(clk), .fsm_rst(fsm_rst), .load(cnt_load), .value(cnt_value),
    .step(busy), .last(cnt_last)
  );

  tcp_opt_asm tcp_opt_asm_i (
    .clk(clk), .fsm_rst(fsm_rst), .opt_load(opt_load), .opt_shift(opt_shift),
    .mss(mss), .mss_pres(mss_pres), .win_scale(win_scale), .win_pres(win_pres),
    .sack_perm_pres(sack_perm_pres), .ts_snd(ts_snd), .ts_rec(ts_rec), .ts_pres(ts_pres),
    .opt_bytes(opt_bytes), .opt_words(opt_words)
  );

  tcp_chsum tcp_chsum_i (
    .clk(clk), .fsm_rst(fsm_rst), .sum_load(sum_load), .sum_step(sum_step),
    .src_ip(src_ip_q), .dst_ip(dst_ip_q), .opt_words(opt_words),
    .payload_len(payload_len_q), .payload_chsum(payload_chsum_q),
    .hdr_bytes(hdr_bytes), .chsum(chsum)
  );

  tcp_tx_ser #(.RAM_DEPTH(RAM_DEPTH)) tcp_tx_ser_i (
    .clk(clk), .fsm_rst(fsm_rst), .build(build), .seal(seal), .send(send),
    .src_port(src_port_q), .dst_port(dst_port_q), .seq_num(seq_num_q),
    .ack_num(ack_num_q), .flags(flags_q), .win_size(win_size_q), .urg_ptr(urg_ptr_q),
    .opt_bytes(opt_bytes), .opt_words(opt_words), .payload_len(payload_len_q),
    .chsum(chsum), .queue_data(queue_data), .hdr_bytes(hdr_bytes),
    .queue_addr(queue_addr), .d(d), .v(v), .sof(sof), .eof(eof)
  );

endmodule

`default_nettype wire
